/* compile.f */
+incdir+test
common/cache_pkg.sv
cache/cache_array.sv
cache/cache_lookup.sv
cache/cache_ctrl.sv
hdl/cache_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_cache
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_defs.svh */
// timeouts in clock cycles
localparam int ACCESS_TIMEOUT = 200;
localparam int HOLD_TIMEOUT   = 20;

// expected mem read activity during one access
localparam logic [1:0] FETCH_ANY = 2'd0;
localparam logic [1:0] FETCH_YES = 2'd1;
localparam logic [1:0] FETCH_NO  = 2'd2;

// memory content before any write, built from the whole line address
function automatic logic [127:0] line_pattern(input logic [27:0] line_addr);
    logic [127:0] line;
    for (int n = 0; n < 4; n++) begin
        line[32*n +: 32] = {2'b10, line_addr, 2'(n)} ^ 32'h3c5a_96e1;
    end
    return line;
endfunction

/* test/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;
    `include "tb_defs.svh"

    typedef enum {MEM_IDLE, MEM_BUSY, MEM_HOLD} mem_phase_e;

    logic              clk;
    logic              proc_reset;
    proc_req_t         proc_req;
    logic              proc_stall;
    logic [WORD_W-1:0] proc_rdata;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    logic [1:0]        exp_fetch;
    int                check_errors;
    int                access_timeouts;
    int                mem_timeouts;
    logic              timed_out;
    logic [127:0]      mem_lines [logic [27:0]];   // lines touched so far

    tb_clock i_clock (.clk(clk), .proc_reset(proc_reset));

    cache_top i_dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    tb_checker i_checker (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_req    (mem_req),
        .exp_fetch  (exp_fetch),
        .errors     (check_errors)
    );

    // one access, driven on a falling edge, held until stall drops
    task automatic run_access(input logic is_write, input proc_addr_t addr,
                              input logic [WORD_W-1:0] data, input logic [1:0] fetch);
        int   waited;
        logic done;
        if (timed_out) begin
            return;
        end
        proc_req.read  = !is_write;
        proc_req.write = is_write;
        proc_req.addr  = addr;
        proc_req.wdata = data;
        exp_fetch      = fetch;
        waited         = 0;
        done           = 1'b0;
        while (!done && waited < ACCESS_TIMEOUT) begin
            @(posedge clk);
            done = !proc_stall;
            waited++;
        end
        if (!done) begin
            $display("timeout: access to address %h did not complete", addr);
            access_timeouts++;
            timed_out = 1'b1;
        end
        @(negedge clk);
        proc_req  = '0;
        exp_fetch = FETCH_ANY;
    endtask

    // memory model, one pulse per request after 1 to 4 cycles
    initial begin
        mem_phase_e  phase;
        logic [1:0]  kind;
        logic [1:0]  served;
        int          delay;
        int          hold_cycles;
        logic [27:0] key;
        mem_rsp = '0;
        phase   = MEM_IDLE;
        forever begin
            @(negedge clk);
            mem_rsp.ready      = 1'b0;
            mem_rsp.rdata.flat = '1;    // junk outside the pulse
            kind               = {mem_req.read, mem_req.write};
            if (proc_reset) begin
                phase = MEM_IDLE;
            end
            if (!proc_reset && phase == MEM_HOLD) begin
                hold_cycles++;
                if (kind != served) begin
                    phase = MEM_IDLE;
                end else if (hold_cycles > HOLD_TIMEOUT) begin
                    $display("timeout: memory request did not change after ready");
                    mem_timeouts++;
                    phase = MEM_IDLE;
                end
            end
            if (!proc_reset && phase == MEM_IDLE && kind != 2'b00) begin
                served = kind;
                delay  = 1 + int'($urandom % 4);
                phase  = MEM_BUSY;
            end else if (phase == MEM_BUSY) begin
                delay--;
                if (delay == 0) begin
                    key = mem_req.addr;
                    if (!mem_lines.exists(key)) begin
                        mem_lines[key] = line_pattern(key);
                    end
                    if (served[0]) begin
                        mem_lines[key] = mem_req.wdata.flat;
                    end
                    mem_rsp.rdata.flat = mem_lines[key];
                    mem_rsp.ready      = 1'b1;
                    hold_cycles        = 0;
                    phase              = MEM_HOLD;
                end
            end
        end
    end

    initial begin
        int         waited;
        int         k;
        proc_addr_t addr;
        void'($urandom(32'h60f0));
        proc_req  = '0;
        exp_fetch = FETCH_ANY;
        timed_out = 1'b0;
        waited    = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (proc_reset && waited < ACCESS_TIMEOUT);
        if (proc_reset) begin
            $display("timeout: reset was never released");
            access_timeouts++;
            timed_out = 1'b1;
        end
        @(negedge clk);

        // cold miss, then a hit in the same line
        run_access(1'b0, {26'h5, 2'd0, 2'd1}, '0, FETCH_YES);
        run_access(1'b0, {26'h5, 2'd0, 2'd3}, '0, FETCH_NO);
        run_access(1'b1, {26'h5, 2'd0, 2'd2}, 32'hdead_beef, FETCH_NO);
        run_access(1'b0, {26'h5, 2'd0, 2'd2}, '0, FETCH_NO);
        // write miss allocates first
        run_access(1'b1, {26'h7, 2'd1, 2'd0}, 32'h1234_5678, FETCH_YES);
        run_access(1'b0, {26'h7, 2'd1, 2'd0}, '0, FETCH_NO);
        // set 2: A, B, A, C must evict B
        run_access(1'b0, {26'h10, 2'd2, 2'd0}, '0, FETCH_YES);
        run_access(1'b0, {26'h11, 2'd2, 2'd1}, '0, FETCH_YES);
        run_access(1'b0, {26'h10, 2'd2, 2'd2}, '0, FETCH_NO);
        run_access(1'b0, {26'h12, 2'd2, 2'd3}, '0, FETCH_YES);
        run_access(1'b0, {26'h10, 2'd2, 2'd3}, '0, FETCH_NO);
        run_access(1'b0, {26'h11, 2'd2, 2'd0}, '0, FETCH_YES);
        // eight lines over three sets, so sets 0 and 1 see evictions
        for (int i = 0; i < 300; i++) begin
            k    = int'($urandom % 8);
            addr = {26'(32'h300 + k), 2'(k % 3), 2'($urandom)};
            run_access($urandom % 2 == 1, addr, $urandom, FETCH_ANY);
        end

        $display("errors: %0d failed checks, %0d access timeouts, %0d memory timeouts",
                 check_errors, access_timeouts, mem_timeouts);
        if (check_errors == 0 && access_timeouts == 0 && mem_timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic                         clk,
    input  logic                         proc_reset,
    input  cache_pkg::proc_req_t         proc_req,
    input  logic                         proc_stall,
    input  logic [cache_pkg::WORD_W-1:0] proc_rdata,
    input  cache_pkg::mem_req_t          mem_req,
    input  logic [1:0]                   exp_fetch,
    output int                           errors
);
    import cache_pkg::*;
    `include "tb_defs.svh"

    logic [WORD_W-1:0] shadow [logic [29:0]];   // words written so far
    logic              after_reset;
    logic              read_q;
    logic              write_q;
    int                reads_seen;              // mem reads in the current access
    int                writes_seen;
    line_u             exp_line;

    task automatic report_fail(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        errors++;
    endtask

    // expected word: last written value, else the memory pattern
    function automatic logic [WORD_W-1:0] ref_word(input proc_addr_t addr);
        line_u line;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        line.flat = line_pattern({addr.tag, addr.index});
        return line.words[addr.offset];
    endfunction

    function automatic line_u expected_write_line(input proc_addr_t addr,
                                                  input logic [WORD_W-1:0] data);
        line_u      line;
        proc_addr_t word_addr;
        word_addr = addr;
        for (int n = 0; n < LINE_WORDS; n++) begin
            word_addr.offset = 2'(n);
            line.words[n]    = ref_word(word_addr);
        end
        line.words[addr.offset] = data;
        return line;
    endfunction

    task automatic complete_access();
        logic [WORD_W-1:0] expected;
        if (proc_req.read) begin
            expected = ref_word(proc_req.addr);
            if (proc_rdata !== expected) begin
                report_fail($sformatf("read %h returned %h, expected %h",
                                      proc_req.addr, proc_rdata, expected));
            end
            if (writes_seen != 0) begin
                report_fail($sformatf("read %h caused a mem write", proc_req.addr));
            end
        end else begin
            if (writes_seen != 1) begin
                report_fail($sformatf("write %h gave %0d mem writes, expected 1",
                                      proc_req.addr, writes_seen));
            end
            shadow[proc_req.addr] = proc_req.wdata;
        end
        if (exp_fetch == FETCH_YES && reads_seen == 0) begin
            report_fail($sformatf("access %h expected a mem read, saw none", proc_req.addr));
        end
        if (exp_fetch == FETCH_NO && reads_seen != 0) begin
            report_fail($sformatf("access %h expected a hit, saw a mem read", proc_req.addr));
        end
        reads_seen  = 0;
        writes_seen = 0;
    endtask

    always @(posedge clk) begin
        if (proc_reset) begin
            after_reset = 1'b1;
            read_q      = 1'b0;
            write_q     = 1'b0;
            reads_seen  = 0;
            writes_seen = 0;
        end else begin
            if (after_reset && (proc_stall || mem_req.read || mem_req.write)) begin
                report_fail("stall, mem read or mem write high after reset");
            end
            after_reset = 1'b0;
            if (mem_req.read && !read_q) begin
                reads_seen++;
                if (mem_req.addr != {proc_req.addr.tag, proc_req.addr.index}) begin
                    report_fail($sformatf("mem read addr %h for access %h",
                                          mem_req.addr, proc_req.addr));
                end
            end
            if (mem_req.write && !write_q) begin
                writes_seen++;
                if (exp_fetch == FETCH_YES && reads_seen == 0) begin
                    report_fail("mem write issued before the line was fetched");
                end
                if (mem_req.addr != {proc_req.addr.tag, proc_req.addr.index}) begin
                    report_fail($sformatf("mem write addr %h for access %h",
                                          mem_req.addr, proc_req.addr));
                end
                exp_line = expected_write_line(proc_req.addr, proc_req.wdata);
                if (mem_req.wdata.flat !== exp_line.flat) begin
                    report_fail($sformatf("mem write line %h, expected %h",
                                          mem_req.wdata.flat, exp_line.flat));
                end
            end
            if ((proc_req.read || proc_req.write) && !proc_stall) begin
                complete_access();
            end
            read_q  = mem_req.read;
            write_q = mem_req.write;
        end
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic proc_reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    initial begin
        proc_reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;          // released on a falling edge
    end

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                            clk,
    input  logic                            proc_reset,
    input  cache_pkg::proc_req_t            proc_req,
    output logic                            proc_stall,
    output logic [cache_pkg::WORD_W-1:0]    proc_rdata,
    output cache_pkg::mem_req_t             mem_req,
    input  cache_pkg::mem_rsp_t             mem_rsp
);
    import cache_pkg::*;

    set_t    set;
    lookup_t result;
    logic    wr_en;
    set_t    wr_set;

    cache_lookup i_lookup (
        .set    (set),
        .addr   (proc_req.addr),
        .result (result)
    );

    // index taken from the held request
    cache_array i_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .rd_index   (proc_req.addr.index),
        .rd_set     (set),
        .wr_en      (wr_en),
        .wr_index   (proc_req.addr.index),
        .wr_set     (wr_set)
    );

    cache_ctrl i_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .set        (set),
        .result     (result),
        .wr_en      (wr_en),
        .wr_set     (wr_set)
    );

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                            clk,
    input  logic                            proc_reset,
    input  cache_pkg::proc_req_t            proc_req,
    output logic                            proc_stall,
    output logic [cache_pkg::WORD_W-1:0]    proc_rdata,
    output cache_pkg::mem_req_t             mem_req,
    input  cache_pkg::mem_rsp_t             mem_rsp,
    input  cache_pkg::set_t                 set,
    input  cache_pkg::lookup_t              result,
    output logic                            wr_en,
    output cache_pkg::set_t                 wr_set
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ_STALL,     // read miss, waiting for the line
        WRITE_FETCH,    // write miss, allocating the line
        WRITE_SEND      // write-through in flight
    } state_e;

    state_e     state;
    state_e     state_nx;
    mem_req_t   req_r;
    mem_req_t   req_nx;
    mem_rsp_t   rsp_r;      // memory response, one cycle late
    line_addr_t line_addr;
    set_t       fill_set;

    // replace one word of a line
    function automatic line_u merge_word(
        line_u               line,
        logic [OFFSET_W-1:0] offset,
        logic [WORD_W-1:0]   data
    );
        line_u merged;
        merged               = line;
        merged.words[offset] = data;
        return merged;
    endfunction

    assign mem_req = req_r;

    always_comb begin
        line_addr.tag   = proc_req.addr.tag;
        line_addr.index = proc_req.addr.index;
    end

    // set with the fetched line placed in the victim way
    always_comb begin
        fill_set                              = set;
        fill_set.way[result.victim_way].valid = 1'b1;
        fill_set.way[result.victim_way].tag   = proc_req.addr.tag;
        fill_set.way[result.victim_way].line  = rsp_r.rdata;
        fill_set.lru                          = ~result.victim_way;
    end

    always_comb begin
        state_nx   = state;
        req_nx     = req_r;
        proc_stall = 1'b0;
        proc_rdata = '0;
        wr_en      = 1'b0;
        wr_set     = set;

        case (state)
            IDLE: begin
                if (proc_req.read) begin
                    if (result.hit) begin
                        proc_rdata = result.word;
                        wr_en      = 1'b1;
                        wr_set.lru = ~result.hit_way;   // true lru on read hits
                    end else begin
                        proc_stall  = 1'b1;
                        req_nx.read = 1'b1;
                        req_nx.addr = line_addr;
                        state_nx    = READ_STALL;
                    end
                end else if (proc_req.write) begin
                    proc_stall  = 1'b1;
                    req_nx.addr = line_addr;
                    if (result.hit) begin
                        wr_en      = 1'b1;
                        wr_set.way[result.hit_way].line = merge_word(
                            set.way[result.hit_way].line,
                            proc_req.addr.offset,
                            proc_req.wdata
                        );
                        wr_set.lru   = ~result.hit_way;
                        req_nx.write = 1'b1;
                        req_nx.wdata = wr_set.way[result.hit_way].line;
                        state_nx     = WRITE_SEND;
                    end else begin
                        req_nx.read = 1'b1;     // allocate first
                        state_nx    = WRITE_FETCH;
                    end
                end
            end

            READ_STALL: begin
                proc_stall = ~rsp_r.ready;
                if (rsp_r.ready) begin
                    proc_rdata  = rsp_r.rdata.words[proc_req.addr.offset];
                    wr_en       = 1'b1;
                    wr_set      = fill_set;
                    req_nx.read = 1'b0;
                    state_nx    = IDLE;
                end
            end

            WRITE_FETCH: begin
                proc_stall = 1'b1;
                if (rsp_r.ready) begin
                    wr_en  = 1'b1;
                    wr_set = fill_set;
                    wr_set.way[result.victim_way].line = merge_word(
                        rsp_r.rdata,
                        proc_req.addr.offset,
                        proc_req.wdata
                    );
                    req_nx.read  = 1'b0;
                    req_nx.write = 1'b1;
                    req_nx.wdata = wr_set.way[result.victim_way].line;
                    state_nx     = WRITE_SEND;
                end
            end

            WRITE_SEND: begin
                proc_stall = ~rsp_r.ready;
                if (rsp_r.ready) begin
                    req_nx.write = 1'b0;
                    state_nx     = IDLE;
                end
            end

            default: begin
                state_nx = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state         <= IDLE;
            req_r.read    <= 1'b0;
            req_r.write   <= 1'b0;
            rsp_r.ready   <= 1'b0;
        end else begin
            state         <= state_nx;
            req_r.read    <= req_nx.read;
            req_r.write   <= req_nx.write;
            rsp_r.ready   <= mem_rsp.ready;
        end
    end

    // request payload and captured line
    always_ff @(posedge clk) begin
        req_r.addr  <= req_nx.addr;
        req_r.wdata <= req_nx.wdata;
        if (mem_rsp.ready) begin
            rsp_r.rdata <= mem_rsp.rdata;   // memory drops data after its pulse
        end
    end

endmodule

/* cache/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup (
    input  cache_pkg::set_t       set,
    input  cache_pkg::proc_addr_t addr,
    output cache_pkg::lookup_t    result
);
    import cache_pkg::*;

    logic [NUM_WAYS-1:0] way_hit;
    logic                hit_way;
    logic                victim_way;
    line_u               hit_line;

    // tag compare against both valid ways
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = set.way[w].valid && (set.way[w].tag == addr.tag);
        end
    end

    assign hit_way  = way_hit[1];   // a tag lives in one way only
    assign hit_line = set.way[hit_way].line;

    // fill order: empty way 0, empty way 1, then the older way
    always_comb begin
        if (!set.way[0].valid) begin
            victim_way = 1'b0;
        end else if (!set.way[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = set.lru;   // lru 1 means way 1 is older
        end
    end

    always_comb begin
        result.hit        = |way_hit;
        result.hit_way    = hit_way;
        result.victim_way = victim_way;
        result.word       = hit_line.words[addr.offset];
    end

endmodule

/* cache/cache_array.sv */
`timescale 1ns/1ps

module cache_array (
    input  logic                            clk,
    input  logic                            proc_reset,
    input  logic [cache_pkg::INDEX_W-1:0]   rd_index,
    output cache_pkg::set_t                 rd_set,
    input  logic                            wr_en,
    input  logic [cache_pkg::INDEX_W-1:0]   wr_index,
    input  cache_pkg::set_t                 wr_set
);
    import cache_pkg::*;

    // state bits, cleared on reset
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic                lru   [NUM_SETS];

    // tag and data storage
    logic [TAG_W-1:0]    tag   [NUM_SETS][NUM_WAYS];
    line_u               line  [NUM_SETS][NUM_WAYS];

    // combinational read of the indexed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_set.way[w].valid = valid[rd_index][w];
            rd_set.way[w].tag   = tag[rd_index][w];
            rd_set.way[w].line  = line[rd_index][w];
        end
        rd_set.lru = lru[rd_index];
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                lru[s]   <= 1'b0;
            end
        end else if (wr_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid[wr_index][w] <= wr_set.way[w].valid;
            end
            lru[wr_index] <= wr_set.lru;
        end
    end

    // whole set written at once
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                tag[wr_index][w]  <= wr_set.way[w].tag;
                line[wr_index][w] <= wr_set.way[w].line;
            end
        end
    end

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

    // geometry
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 2;
    localparam int INDEX_W    = 2;
    localparam int TAG_W      = 26;
    localparam int NUM_SETS   = 4;
    localparam int NUM_WAYS   = 2;

    // processor word address, msb to lsb: tag, index, offset
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } proc_addr_t;

    // memory line address
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } line_addr_t;

    // one cache line, as the memory bus sees it or word by word
    typedef union packed {
        logic [LINE_WORDS*WORD_W-1:0]           flat;
        logic [LINE_WORDS-1:0][WORD_W-1:0]      words;  // words[n] at bits 32n+31:32n
    } line_u;

    typedef struct packed {
        logic              read;
        logic              write;
        proc_addr_t        addr;
        logic [WORD_W-1:0] wdata;
    } proc_req_t;

    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_u      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;   // single-cycle pulse
        line_u rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        line_u            line;
    } way_t;

    typedef struct packed {
        way_t [NUM_WAYS-1:0] way;
        logic                lru;   // 1: way 0 used most recently
    } set_t;

    typedef struct packed {
        logic              hit;
        logic              hit_way;
        logic              victim_way;
        logic [WORD_W-1:0] word;    // hit word at the address offset
    } lookup_t;

endpackage
